//--- hdl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// ----------------------------------------------------------------------
// Memory map and reset sizes
// ----------------------------------------------------------------------

// 16-bit bus, 64 KB address space
`define CPU_ADDR_W    16

// One byte per address
`define CPU_MEM_DEPTH 65536

// First opcode fetched after reset
`define CPU_RESET_PC  16'h0400

`endif

//--- hdl/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

    // ------------------------------------------------------------------
    // Core sequencer states
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        ST_FETCH = 4'h0, // Opcode read at PC
        ST_IND_X = 4'h1, // (zp,X) pointer walk
        ST_IND_Y = 4'h2, // (zp),Y pointer walk
        ST_ZP    = 4'h3,
        ST_ZP_X  = 4'h4,
        ST_ABS   = 4'h5, // Two operand bytes
        ST_ABS_X = 4'h6,
        ST_ABS_Y = 4'h7,
        ST_EXEC  = 4'h8, // Operand on the bus, result latched
        ST_WBACK = 4'h9  // After STA strobe
    } cpu_state_e;

    // Group-one addressing modes, opcode bits 4:2
    typedef enum logic [2:0] {
        AM_IND_X = 3'd0,
        AM_ZP    = 3'd1,
        AM_IMM   = 3'd2,
        AM_ABS   = 3'd3,
        AM_IND_Y = 3'd4,
        AM_ZP_X  = 3'd5,
        AM_ABS_Y = 3'd6,
        AM_ABS_X = 3'd7
    } addr_mode_e;

    typedef enum logic [1:0] {
        ALU_ORA, ALU_AND, ALU_EOR, ALU_LDA
    } alu_op_e;

    // What the execute cycle does with the operand
    typedef enum logic [2:0] {
        CLS_NOP, CLS_ALU, CLS_STA, CLS_LDX, CLS_LDY
    } insn_class_e;

    localparam logic [7:0] OPC_LDX_IMM = 8'hA2;
    localparam logic [7:0] OPC_LDY_IMM = 8'hA0;

    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] addr;  // Read and write address
        logic [7:0]             wdata;
        logic                   we;    // One-cycle write strobe
    } mem_bus_t;

    // Status register, bit 7 down to bit 0
    typedef struct packed {
        logic n;
        logic v;
        logic one;
        logic b;
        logic d;
        logic i;
        logic z;
        logic c;
    } cpu_flags_t;

endpackage

//--- hdl/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
    input  cpu_pkg::alu_op_e    i_op,
    input  logic [7:0]          i_a,       // Accumulator
    input  logic [7:0]          i_operand, // Byte read this cycle
    input  cpu_pkg::cpu_flags_t i_flags,
    output logic [7:0]          o_result,
    output cpu_pkg::cpu_flags_t o_flags
);

    import cpu_pkg::*;

    // ------------------------------------------------------------------
    // Logic operations
    // ------------------------------------------------------------------

    always_comb begin
        case (i_op)
            ALU_ORA: o_result = i_a | i_operand;
            ALU_AND: o_result = i_a & i_operand;
            ALU_EOR: o_result = i_a ^ i_operand;
            default: o_result = i_operand; // LDA, straight load
        endcase
    end

    // ------------------------------------------------------------------
    // Flag update
    // ------------------------------------------------------------------

    // Only N and Z move, the rest pass through
    always_comb begin
        o_flags   = i_flags;
        o_flags.n = o_result[7];          // Sign bit
        o_flags.z = (o_result == 8'h00);  // Result zero
    end

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_core (
    input  logic              clock_25,
    input  logic              i_rst_n,
    input  logic [7:0]        i_rdata, // Byte at o_bus.addr, same cycle
    output cpu_pkg::mem_bus_t o_bus
);

    import cpu_pkg::*;

    // ------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------

    logic [7:0]             a_reg;   // Accumulator
    logic [7:0]             x_reg;   // Index X
    logic [7:0]             y_reg;   // Index Y
    cpu_flags_t             flags;   // N V 1 B D I Z C
    logic [`CPU_ADDR_W-1:0] pc;

    cpu_state_e             state;
    logic [1:0]             step;    // Sub-cycle inside an addressing state
    logic                   alt;     // 1 = bus on addr, 0 = bus on PC
    logic [7:0]             opcode;  // Latched in ST_FETCH
    logic [`CPU_ADDR_W-1:0] addr;    // Effective or pointer address
    logic [7:0]             ptr_lo;  // Low byte held for the high byte read

    // ------------------------------------------------------------------
    // Decode helpers
    // ------------------------------------------------------------------

    function automatic insn_class_e decode_class(input logic [7:0] opc);
        insn_class_e cls;
        cls = CLS_NOP;
        if (opc == OPC_LDX_IMM) begin
            cls = CLS_LDX;
        end else if (opc == OPC_LDY_IMM) begin
            cls = CLS_LDY;
        end else if (opc[1:0] == 2'b01) begin   // Group one
            case (opc[7:5])
                3'b000, 3'b001, 3'b010, 3'b101: cls = CLS_ALU;
                3'b100:                         cls = CLS_STA;
                default:                        cls = CLS_NOP; // ADC, CMP, SBC left out
            endcase
        end
        return cls;
    endfunction

    // First operand state for a group-one mode
    function automatic cpu_state_e mode_state(input addr_mode_e am);
        case (am)
            AM_IND_X: return ST_IND_X;
            AM_ZP:    return ST_ZP;
            AM_ABS:   return ST_ABS;
            AM_IND_Y: return ST_IND_Y;
            AM_ZP_X:  return ST_ZP_X;
            AM_ABS_Y: return ST_ABS_Y;
            AM_ABS_X: return ST_ABS_X;
            default:  return ST_EXEC;  // #imm, operand read straight at PC
        endcase
    endfunction

    function automatic alu_op_e alu_op_of(input logic [7:0] opc);
        case (opc[7:5])
            3'b000:  return ALU_ORA;
            3'b001:  return ALU_AND;
            3'b010:  return ALU_EOR;
            default: return ALU_LDA;
        endcase
    endfunction

    insn_class_e fetch_cls;  // Class of the byte being fetched
    insn_class_e exec_cls;   // Class of the latched opcode
    logic        alu_exec;   // A and flags load this cycle
    logic        sta_exec;   // Write strobe cycle

    assign fetch_cls = decode_class(i_rdata);
    assign exec_cls  = decode_class(opcode);
    assign alu_exec  = (state == ST_EXEC) && (exec_cls == CLS_ALU);
    assign sta_exec  = (state == ST_EXEC) && (exec_cls == CLS_STA);

    // ------------------------------------------------------------------
    // Address arithmetic
    // ------------------------------------------------------------------

    logic [7:0]             zp_idx;
    logic [7:0]             zp_addr;   // Wraps inside page zero
    logic [7:0]             abs_idx;
    logic [`CPU_ADDR_W-1:0] full_addr; // Wraps at 64 KB

    assign zp_idx    = (state == ST_IND_X || state == ST_ZP_X) ? x_reg : 8'h00;
    assign zp_addr   = i_rdata + zp_idx;
    assign abs_idx   = (state == ST_IND_Y || state == ST_ABS_Y) ? y_reg :
                       (state == ST_ABS_X) ? x_reg : 8'h00;
    assign full_addr = {i_rdata, ptr_lo} + {8'h00, abs_idx};

    // ------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------

    logic [7:0] alu_result;
    cpu_flags_t alu_flags;

    cpu_alu cpu_alu_i (
        .i_op      (alu_op_of(opcode)),
        .i_a       (a_reg),
        .i_operand (i_rdata),
        .i_flags   (flags),
        .o_result  (alu_result),
        .o_flags   (alu_flags)
    );

    // Bus routing, write data is always A
    always_comb begin
        o_bus.addr  = alt ? addr : pc;
        o_bus.wdata = a_reg;
        o_bus.we    = sta_exec;
    end

    // ------------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------------

    always_ff @(posedge clock_25) begin
        if (!i_rst_n) begin
            state <= ST_FETCH;
            step  <= 2'd0;
            alt   <= 1'b0;
            pc    <= `CPU_RESET_PC;
            a_reg <= 8'h00;
            x_reg <= 8'h00;
            y_reg <= 8'h00;
            flags <= '0;
        end else begin
            case (state)
                ST_FETCH: begin
                    opcode <= i_rdata;
                    pc     <= pc + 1'b1;
                    step   <= 2'd0;
                    if (fetch_cls == CLS_ALU || fetch_cls == CLS_STA) begin
                        state <= mode_state(addr_mode_e'(i_rdata[4:2]));
                    end else begin
                        state <= ST_EXEC;  // LDX, LDY, NOP
                    end
                end

                // Pointer walk, zero page then two pointer bytes
                ST_IND_X, ST_IND_Y: begin
                    case (step)
                        2'd0: begin
                            addr <= {8'h00, zp_addr}; // +X only for (zp,X)
                            pc   <= pc + 1'b1;
                            alt  <= 1'b1;
                            step <= 2'd1;
                        end
                        2'd1: begin
                            ptr_lo    <= i_rdata;
                            addr[7:0] <= addr[7:0] + 1'b1; // High byte stays in page zero
                            step      <= 2'd2;
                        end
                        default: begin
                            addr  <= full_addr;   // +Y only for (zp),Y
                            step  <= 2'd0;
                            state <= ST_EXEC;
                        end
                    endcase
                end

                ST_ZP, ST_ZP_X: begin
                    addr  <= {8'h00, zp_addr};
                    pc    <= pc + 1'b1;
                    alt   <= 1'b1;
                    state <= ST_EXEC;
                end

                ST_ABS, ST_ABS_X, ST_ABS_Y: begin
                    pc <= pc + 1'b1;
                    if (step == 2'd0) begin
                        ptr_lo <= i_rdata;       // Low byte
                        step   <= 2'd1;
                    end else begin
                        addr  <= full_addr;      // High byte plus index
                        alt   <= 1'b1;
                        step  <= 2'd0;
                        state <= ST_EXEC;
                    end
                end

                ST_EXEC: begin
                    if (!alt && exec_cls != CLS_NOP) begin
                        pc <= pc + 1'b1;         // Immediate operand consumed
                    end
                    if (alu_exec) begin
                        a_reg <= alu_result;
                        flags <= alu_flags;
                    end
                    if (exec_cls == CLS_LDX) x_reg <= i_rdata;
                    if (exec_cls == CLS_LDY) y_reg <= i_rdata;
                    if (sta_exec) begin
                        state <= ST_WBACK;       // Bus held on addr for the strobe
                    end else begin
                        alt   <= 1'b0;
                        state <= ST_FETCH;
                    end
                end

                ST_WBACK: begin
                    alt   <= 1'b0;               // Back to PC
                    state <= ST_FETCH;
                end

                default: state <= ST_FETCH;
            endcase
        end
    end

endmodule

//--- hdl/cpu_mem.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_mem (
    input  logic                   clock_25,
    input  cpu_pkg::mem_bus_t      i_bus,       // From the core
    input  logic                   i_load_we,   // Program loader
    input  logic [`CPU_ADDR_W-1:0] i_load_addr,
    input  logic [7:0]             i_load_data,
    output logic [7:0]             o_rdata
);

    // Whole 64 KB space, one byte per address
    logic [7:0] mem [0:`CPU_MEM_DEPTH-1];

    // ------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------

    // Same-cycle answer, no wait states
    assign o_rdata = mem[i_bus.addr];

    // ------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------

    always_ff @(posedge clock_25) begin
        if (i_load_we) begin
            mem[i_load_addr] <= i_load_data;   // Loader has priority
        end else if (i_bus.we) begin
            mem[i_bus.addr] <= i_bus.wdata;    // STA strobe
        end
    end

endmodule

//--- hdl/cpu_system.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_system (
    input  logic                   clock_25,
    input  logic                   i_rst_n,
    // Memory fill port, used while the core sits in reset
    input  logic                   i_load_we,
    input  logic [`CPU_ADDR_W-1:0] i_load_addr,
    input  logic [7:0]             i_load_data,
    // Core bus, visible outside for monitoring
    output cpu_pkg::mem_bus_t      o_bus_mon
);

    logic [7:0] rdata; // Memory to core, combinational

    // ------------------------------------------------------------------
    // Processor
    // ------------------------------------------------------------------

    cpu_core cpu_core_i (
        .clock_25 (clock_25),
        .i_rst_n  (i_rst_n),
        .i_rdata  (rdata),
        .o_bus    (o_bus_mon)    // Drives memory and the monitor port
    );

    // ------------------------------------------------------------------
    // Memory
    // ------------------------------------------------------------------

    cpu_mem cpu_mem_i (
        .clock_25    (clock_25),
        .i_bus       (o_bus_mon),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .o_rdata     (rdata)
    );

endmodule

//--- bench/cpu_system_asserts.sv
`timescale 1ns/1ps

module cpu_system_asserts (
    input logic                clock_25,
    input logic                i_rst_n,
    input cpu_pkg::cpu_state_e i_state,
    input cpu_pkg::mem_bus_t   i_bus,
    input logic [7:0]          i_a,        // Accumulator
    input cpu_pkg::cpu_flags_t i_flags,
    input logic                i_alu_exec  // ALU result loads this cycle
);

    import cpu_pkg::*;

    // ------------------------------------------------------------------
    // Core protocol
    // ------------------------------------------------------------------

    // STA strobe never stretches
    we_single: assert property (@(posedge clock_25) disable iff (!i_rst_n)
        i_bus.we |=> !i_bus.we)
        else $error("write strobe high for more than one cycle");

    reset_idle: assert property (@(posedge clock_25)
        !i_rst_n |=> (i_state == ST_FETCH && !i_bus.we))
        else $error("core not idle in ST_FETCH after reset");

    // N and Z follow the new A
    nz_flags: assert property (@(posedge clock_25) disable iff (!i_rst_n)
        i_alu_exec |=> (i_flags.z == (i_a == 8'h00) && i_flags.n == i_a[7]))
        else $error("N or Z flag does not match A after an ALU cycle");

endmodule

bind cpu_core cpu_system_asserts cpu_system_asserts_i (
    .clock_25   (clock_25),
    .i_rst_n    (i_rst_n),
    .i_state    (state),
    .i_bus      (o_bus),
    .i_a        (a_reg),
    .i_flags    (flags),
    .i_alu_exec (alu_exec)
);

//--- bench/cpu_system_tb.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_system_tb;

    import cpu_pkg::*;

    localparam int N_BLOCKS     = 40;
    // Blocks x instructions x cycles x clock period x 2
    localparam int RUN_LIMIT_NS = N_BLOCKS * 6 * 6 * 4 * 2;

    logic                   clock_25  = 1'b0;
    logic                   rst_n     = 1'b0;   // Held low through the load
    logic                   load_we   = 1'b0;
    logic [`CPU_ADDR_W-1:0] load_addr = '0;
    logic [7:0]             load_data = 8'h00;
    mem_bus_t               bus_mon;

    integer                 seed;
    logic [7:0]             model_mem [0:`CPU_MEM_DEPTH-1];  // Reference copy of memory
    logic [15:0]            prog_pc;   // Generator write pointer
    logic [15:0]            m_pc;      // Model registers
    logic [7:0]             m_a;
    logic [7:0]             m_x;
    logic [7:0]             m_y;

    cpu_system cpu_system_i (
        .clock_25    (clock_25),
        .i_rst_n     (rst_n),
        .i_load_we   (load_we),
        .i_load_addr (load_addr),
        .i_load_data (load_data),
        .o_bus_mon   (bus_mon)
    );

    always #2 clock_25 = ~clock_25;  // 4 ns period

    // ------------------------------------------------------------------
    // Failure exit and random helpers
    // ------------------------------------------------------------------

    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    // ------------------------------------------------------------------
    // Program generator
    // ------------------------------------------------------------------

    task automatic emit(input logic [7:0] b);
        model_mem[prog_pc] = b;
        prog_pc = prog_pc + 16'd1;
    endtask

    // Loads stay in 4000..7FFF while stores may also land in 8000..BFFF
    task automatic emit_operand(input logic [2:0] mode, input logic is_store);
        logic [15:0] base;
        case (mode)
            3'd3, 3'd6, 3'd7: begin
                if (is_store && rand_below(2) == 1) begin
                    base = 16'(32'h8000 + rand_below(32'h3F00));
                end else begin
                    base = 16'(32'h4000 + rand_below(32'h3F00));  // Index stays below 8000
                end
                emit(base[7:0]);
                emit(base[15:8]);
            end
            default: emit(rand_byte());  // #imm or page-zero offset
        endcase
    endtask

    task automatic gen_block();
        logic [7:0] xv;
        logic [2:0] aaa;
        logic [2:0] mode;
        int         n;
        xv = rand_byte();
        if (rand_below(2) == 1) xv = 8'hF0 | xv;  // Near FF so zp sums wrap
        emit(OPC_LDX_IMM);
        emit(xv);
        emit(OPC_LDY_IMM);
        emit(rand_byte());
        n = 1 + rand_below(4);
        for (int i = 0; i < n; i++) begin
            case (rand_below(4))
                0:       aaa = 3'b000;  // ORA
                1:       aaa = 3'b001;  // AND
                2:       aaa = 3'b010;  // EOR
                default: aaa = 3'b101;  // LDA
            endcase
            mode = 3'(rand_below(8));
            emit({aaa, mode, 2'b01});
            emit_operand(mode, 1'b0);
        end
        // STA never hits page zero so the pointers survive
        case (rand_below(5))
            0:       mode = 3'd0;
            1:       mode = 3'd3;
            2:       mode = 3'd4;
            3:       mode = 3'd6;
            default: mode = 3'd7;
        endcase
        emit({3'b100, mode, 2'b01});
        emit_operand(mode, 1'b1);
    endtask

    task automatic build_image();
        for (int a = 0; a < 256; a++) begin
            model_mem[a] = 8'(32'h40 + rand_below(63));  // Pointer bytes 40..7E
        end
        for (int a = 16'h4000; a <= 16'h7FFF; a++) begin
            model_mem[a] = rand_byte();
        end
        prog_pc = `CPU_RESET_PC;
        for (int b = 0; b < N_BLOCKS; b++) begin
            gen_block();
        end
    endtask

    // ------------------------------------------------------------------
    // Loader port
    // ------------------------------------------------------------------

    task automatic load_range(input int lo, input int hi);
        for (int a = lo; a <= hi; a++) begin
            @(posedge clock_25);
            load_we   <= 1'b1;
            load_addr <= 16'(a);
            load_data <= model_mem[a];
        end
    endtask

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    task automatic operand_addr(input logic [2:0] mode, output logic [15:0] ea);
        logic [7:0]  zp;
        logic [7:0]  zp_next;
        logic [15:0] base;
        case (mode)
            3'd0: begin                                   // (zp,X)
                zp      = model_mem[m_pc] + m_x;
                zp_next = zp + 8'd1;                      // Wraps in page zero
                ea      = {model_mem[{8'h00, zp_next}], model_mem[{8'h00, zp}]};
                m_pc    = m_pc + 16'd1;
            end
            3'd1: begin                                   // zp
                ea   = {8'h00, model_mem[m_pc]};
                m_pc = m_pc + 16'd1;
            end
            3'd2: begin                                   // #imm
                ea   = m_pc;
                m_pc = m_pc + 16'd1;
            end
            3'd4: begin                                   // (zp),Y
                zp      = model_mem[m_pc];
                zp_next = zp + 8'd1;
                ea      = {model_mem[{8'h00, zp_next}], model_mem[{8'h00, zp}]} + {8'h00, m_y};
                m_pc    = m_pc + 16'd1;
            end
            3'd5: begin                                   // zp,X
                zp   = model_mem[m_pc] + m_x;
                ea   = {8'h00, zp};
                m_pc = m_pc + 16'd1;
            end
            default: begin                                // abs, abs,Y, abs,X
                base = {model_mem[m_pc + 16'd1], model_mem[m_pc]};
                m_pc = m_pc + 16'd2;
                if (mode == 3'd6) begin
                    ea = base + {8'h00, m_y};
                end else if (mode == 3'd7) begin
                    ea = base + {8'h00, m_x};
                end else begin
                    ea = base;
                end
            end
        endcase
    endtask

    // Runs instructions until the next STA
    task automatic model_next_store(output logic [15:0] st_addr, output logic [7:0] st_data);
        logic [7:0]  opc;
        logic [15:0] ea;
        logic        done;
        int          steps;
        done  = 1'b0;
        steps = 0;
        while (!done) begin
            steps = steps + 1;
            assert (steps <= 16) else begin
                $display("Reference model found no store within 16 instructions");
                stop_on_failure();
            end
            opc  = model_mem[m_pc];
            m_pc = m_pc + 16'd1;
            if (opc == OPC_LDX_IMM) begin
                m_x  = model_mem[m_pc];
                m_pc = m_pc + 16'd1;
            end else if (opc == OPC_LDY_IMM) begin
                m_y  = model_mem[m_pc];
                m_pc = m_pc + 16'd1;
            end else if (opc[1:0] == 2'b01) begin
                operand_addr(opc[4:2], ea);
                case (opc[7:5])
                    3'b000: m_a = m_a | model_mem[ea];
                    3'b001: m_a = m_a & model_mem[ea];
                    3'b010: m_a = m_a ^ model_mem[ea];
                    3'b101: m_a = model_mem[ea];
                    3'b100: begin
                        model_mem[ea] = m_a;   // Later reads see the store
                        st_addr       = ea;
                        st_data       = m_a;
                        done          = 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Store monitor and checks
    // ------------------------------------------------------------------

    task automatic wait_store(output logic [15:0] addr, output logic [7:0] data);
        do begin
            @(negedge clock_25);   // Bus settled mid-cycle
        end while (bus_mon.we !== 1'b1);
        addr = bus_mon.addr;
        data = bus_mon.wdata;
    endtask

    task automatic check_value(input string name, input int idx,
                               input logic [15:0] exp, input logic [15:0] got);
        assert (got === exp) else begin
            $display("ERR %s #%0d expected %h actual %h", name, idx, exp, got);
            stop_on_failure();
        end
    endtask

    initial begin : watchdog
        wait (rst_n === 1'b1);
        #(RUN_LIMIT_NS);
        $display("Timeout, the DUT did not issue all %0d stores in time", N_BLOCKS);
        stop_on_failure();
    end

    initial begin : main
        logic [15:0] exp_addr;
        logic [15:0] got_addr;
        logic [7:0]  exp_data;
        logic [7:0]  got_data;
        seed = 32'h6984;
        build_image();
        load_range(16'h0000, 16'h00FF);
        load_range(16'h4000, 16'h7FFF);
        load_range(`CPU_RESET_PC, int'(prog_pc) - 1);
        @(posedge clock_25);
        load_we <= 1'b0;
        repeat (5) @(posedge clock_25);   // Reset tail after the load
        rst_n <= 1'b1;
        m_pc = `CPU_RESET_PC;
        m_a  = 8'h00;
        m_x  = 8'h00;
        m_y  = 8'h00;
        for (int n = 0; n < N_BLOCKS; n++) begin
            model_next_store(exp_addr, exp_data);
            wait_store(got_addr, got_data);
            check_value("store_addr", n, exp_addr, got_addr);
            check_value("store_data", n, {8'h00, exp_data}, {8'h00, got_data});
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/cpu_alu.sv
hdl/cpu_core.sv
hdl/cpu_mem.sv
hdl/cpu_system.sv
bench/cpu_system_asserts.sv
bench/cpu_system_tb.sv

//--- Makefile
# Verilator flow for the cpu_system testbench

TOP := cpu_system_tb
BIN := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): sources.f hdl/cpu_cfg.svh hdl/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f sources.f -Mdir obj_dir

# Pass only when the log holds the pass line
run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
